// File: rtl/soc_pkg.sv
package soc_pkg;

  // SRAM word address
  typedef logic [7:0] addr_t;

  // One data word
  typedef logic [31:0] data_t;

  // Copy length in words
  typedef logic [7:0] len_t;

  // Host command opcodes
  typedef enum logic [1:0] {
    OP_WRITE  = 2'd0,
    OP_READ   = 2'd1,
    OP_STATUS = 2'd2,
    OP_COPY   = 2'd3
  } host_op_e;

  // Command held by the host agent while it requests
  typedef struct packed {
    host_op_e op;
    addr_t    addr;   // Destination address for OP_COPY
    addr_t    src;
    len_t     len;
    data_t    wdata;
  } host_cmd_t;

  // Answer that is valid while the host ack is high
  typedef struct packed {
    data_t rdata;
    logic  busy;
  } host_rsp_t;

  // One SRAM access as issued by a bus master
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Job handed from the host port to the copy engine
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } copy_job_t;

endpackage

// File: rtl/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned NumWords = 256
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              mem_en_i,
  input  soc_pkg::bus_req_t mem_bus_i,
  output soc_pkg::data_t    mem_rdata_o
);

  import soc_pkg::*;

  // Index width, at least one bit
  localparam int unsigned IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  data_t           mem_q [NumWords];
  logic [IdxW-1:0] idx;
  data_t           rdata_q;

  // Upper address bits are dropped, so addresses wrap at NumWords
  assign idx = mem_bus_i.addr[IdxW-1:0];

  // Write port
  always_ff @(posedge clk_i) begin
    if (mem_en_i && mem_bus_i.we) begin
      mem_q[idx] <= mem_bus_i.wdata;
    end
  end

  // Registered read, data appears the cycle after the enable
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (mem_en_i && !mem_bus_i.we) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign mem_rdata_o = rdata_q;

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Master 0, host port
  input  logic              m0_req_i,
  input  soc_pkg::bus_req_t m0_bus_i,
  output logic              m0_ack_o,
  output soc_pkg::data_t    m0_rdata_o,
  // Master 1, copy engine
  input  logic              m1_req_i,
  input  soc_pkg::bus_req_t m1_bus_i,
  output logic              m1_ack_o,
  output soc_pkg::data_t    m1_rdata_o,
  // SRAM side
  output logic              mem_en_o,
  output soc_pkg::bus_req_t mem_bus_o,
  input  soc_pkg::data_t    mem_rdata_i
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    HOLD
  } arb_state_e;

  arb_state_e state_q;
  logic       last_q;    // Master served last, also the current grant
  logic       sel;
  logic       any_req;
  logic       gnt_req;
  data_t      rdata_q;

  assign any_req = m0_req_i | m1_req_i;

  // On a tie the master not served last wins
  always_comb begin
    if (m0_req_i && m1_req_i) begin
      sel = ~last_q;
    end else begin
      sel = m1_req_i;
    end
  end

  // Grant and access share the IDLE cycle
  assign mem_en_o  = (state_q == IDLE) && any_req;
  assign mem_bus_o = sel ? m1_bus_i : m0_bus_i;

  // Request line of the granted master
  assign gnt_req = last_q ? m1_req_i : m0_req_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      last_q  <= 1'b1;
    end else begin
      case (state_q)
        IDLE: begin
          if (any_req) begin
            last_q  <= sel;
            state_q <= ACCESS;
          end
        end
        ACCESS:  state_q <= HOLD;
        // Grant held until the master lets go
        HOLD: begin
          if (!gnt_req) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Read data register, loaded as the SRAM answers
  always_ff @(posedge clk_i) begin
    if (state_q == ACCESS) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign m0_ack_o   = (state_q == HOLD) && !last_q;
  assign m1_ack_o   = (state_q == HOLD) && last_q;
  assign m0_rdata_o = rdata_q;
  assign m1_rdata_o = rdata_q;

  // A master only lets go of its request while it is acknowledged
  a_m0_req_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(m0_req_i) |-> m0_ack_o);

  a_m1_req_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(m1_req_i) |-> m1_ack_o);

endmodule

// File: rtl/host_port.sv
`timescale 1ns/1ps

module host_port (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Host handshake
  input  logic               host_req_i,
  input  soc_pkg::host_cmd_t host_cmd_i,
  output logic               host_ack_o,
  output soc_pkg::host_rsp_t host_rsp_o,
  // Bus master side
  output logic               bus_req_o,
  output soc_pkg::bus_req_t  bus_o,
  input  logic               bus_ack_i,
  input  soc_pkg::data_t     bus_rdata_i,
  // Copy job side
  output logic               copy_req_o,
  output soc_pkg::copy_job_t copy_job_o,
  input  logic               copy_ack_i,
  input  logic               copy_busy_i
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    COPY,
    ACK
  } hp_state_e;

  hp_state_e state_q;
  logic      bus_req_q;
  logic      copy_req_q;
  data_t     rdata_q;
  logic      busy_q;

  // Command stays stable until ack, so it drives downstream directly
  assign bus_o.we        = (host_cmd_i.op == OP_WRITE);
  assign bus_o.addr      = host_cmd_i.addr;
  assign bus_o.wdata     = host_cmd_i.wdata;
  assign copy_job_o.src  = host_cmd_i.src;
  assign copy_job_o.dst  = host_cmd_i.addr;
  assign copy_job_o.len  = host_cmd_i.len;

  assign bus_req_o        = bus_req_q;
  assign copy_req_o       = copy_req_q;
  assign host_ack_o       = (state_q == ACK);
  assign host_rsp_o.rdata = rdata_q;
  assign host_rsp_o.busy  = busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      bus_req_q  <= 1'b0;
      copy_req_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (host_req_i) begin
            case (host_cmd_i.op)
              OP_WRITE, OP_READ: begin
                bus_req_q <= 1'b1;
                state_q   <= BUS;
              end
              OP_COPY: begin
                copy_req_q <= 1'b1;
                state_q    <= COPY;
              end
              default: state_q <= ACK;
            endcase
          end
        end
        // Drop req on ack, move on once ack has fallen
        BUS: begin
          if (bus_req_q && bus_ack_i) begin
            bus_req_q <= 1'b0;
          end else if (!bus_req_q && !bus_ack_i) begin
            state_q <= ACK;
          end
        end
        // Waits here while the engine is busy
        COPY: begin
          if (copy_req_q && copy_ack_i) begin
            copy_req_q <= 1'b0;
          end else if (!copy_req_q && !copy_ack_i) begin
            state_q <= ACK;
          end
        end
        ACK: begin
          if (!host_req_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Response capture
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && host_req_i) begin
      rdata_q <= '0;
    end else if (state_q == BUS && bus_req_q && bus_ack_i) begin
      rdata_q <= bus_rdata_i;
    end
    // Frozen once ack is up
    if (state_q != ACK) begin
      busy_q <= copy_busy_i;
    end
  end

  // Host keeps its request up until it has been acknowledged
  a_req_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(host_req_i) |-> host_ack_o);

endmodule

// File: rtl/copy_engine.sv
`timescale 1ns/1ps

module copy_engine (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Job handshake
  input  logic               copy_req_i,
  input  soc_pkg::copy_job_t copy_job_i,
  output logic               copy_ack_o,
  output logic               copy_busy_o,
  // Bus master side
  output logic               bus_req_o,
  output soc_pkg::bus_req_t  bus_o,
  input  logic               bus_ack_i,
  input  soc_pkg::data_t     bus_rdata_i
);

  import soc_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ACCEPT,
    RD,
    WR,
    NEXT
  } ce_state_e;

  ce_state_e state_q;
  logic      bus_req_q;
  len_t      left_q;
  addr_t     src_q;
  addr_t     dst_q;
  data_t     buf_q;
  logic      xfer_done;

  // Bus handshake over: req dropped and ack fell
  assign xfer_done = !bus_req_q && !bus_ack_i;

  assign copy_ack_o  = (state_q == ACCEPT);
  assign copy_busy_o = (state_q != IDLE);

  assign bus_req_o   = bus_req_q;
  assign bus_o.we    = (state_q == WR);
  assign bus_o.addr  = (state_q == WR) ? dst_q : src_q;
  assign bus_o.wdata = buf_q;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      bus_req_q <= 1'b0;
      left_q    <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (copy_req_i) begin
            left_q  <= copy_job_i.len;
            state_q <= ACCEPT;
          end
        end
        // Zero length finishes right after the handshake
        ACCEPT: begin
          if (!copy_req_i) begin
            if (left_q == '0) begin
              state_q <= IDLE;
            end else begin
              bus_req_q <= 1'b1;
              state_q   <= RD;
            end
          end
        end
        RD: begin
          if (bus_req_q && bus_ack_i) begin
            bus_req_q <= 1'b0;
          end else if (xfer_done) begin
            bus_req_q <= 1'b1;
            state_q   <= WR;
          end
        end
        WR: begin
          if (bus_req_q && bus_ack_i) begin
            bus_req_q <= 1'b0;
          end else if (xfer_done) begin
            state_q <= NEXT;
          end
        end
        NEXT: begin
          left_q <= left_q - len_t'(1);
          if (left_q == len_t'(1)) begin
            state_q <= IDLE;
          end else begin
            bus_req_q <= 1'b1;
            state_q   <= RD;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and word buffer
  ////////////////////////////////////////////////////////////////////////////

  // 8-bit pointers wrap at 256, the SRAM index at NumWords
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && copy_req_i) begin
      src_q <= copy_job_i.src;
      dst_q <= copy_job_i.dst;
    end else if (state_q == NEXT) begin
      src_q <= src_q + addr_t'(1);
      dst_q <= dst_q + addr_t'(1);
    end
    if (state_q == RD && bus_req_q && bus_ack_i) begin
      buf_q <= bus_rdata_i;
    end
  end

  // A new job only starts once the last bus access has ended
  a_accept_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    copy_ack_o |-> !bus_req_o && !bus_ack_i);

endmodule

// File: rtl/mini_soc.sv
`timescale 1ns/1ps

module mini_soc #(
  parameter int unsigned NumWords = 256
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               host_req_i,
  input  soc_pkg::host_cmd_t host_cmd_i,
  output logic               host_ack_o,
  output soc_pkg::host_rsp_t host_rsp_o,
  output logic               copy_busy_o
);

  import soc_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////////////////////

  logic      copy_req;
  copy_job_t copy_job;
  logic      copy_ack;

  // Host master
  logic      m0_req;
  bus_req_t  m0_bus;
  logic      m0_ack;
  data_t     m0_rdata;

  // Copy master
  logic      m1_req;
  bus_req_t  m1_bus;
  logic      m1_ack;
  data_t     m1_rdata;

  logic      mem_en;
  bus_req_t  mem_bus;
  data_t     mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  host_port i_host_port (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .host_req_i  ( host_req_i  ),
    .host_cmd_i  ( host_cmd_i  ),
    .host_ack_o  ( host_ack_o  ),
    .host_rsp_o  ( host_rsp_o  ),
    .bus_req_o   ( m0_req      ),
    .bus_o       ( m0_bus      ),
    .bus_ack_i   ( m0_ack      ),
    .bus_rdata_i ( m0_rdata    ),
    .copy_req_o  ( copy_req    ),
    .copy_job_o  ( copy_job    ),
    .copy_ack_i  ( copy_ack    ),
    .copy_busy_i ( copy_busy_o )
  );

  copy_engine i_copy_engine (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .copy_req_i  ( copy_req    ),
    .copy_job_i  ( copy_job    ),
    .copy_ack_o  ( copy_ack    ),
    .copy_busy_o ( copy_busy_o ),
    .bus_req_o   ( m1_req      ),
    .bus_o       ( m1_bus      ),
    .bus_ack_i   ( m1_ack      ),
    .bus_rdata_i ( m1_rdata    )
  );

  mem_arbiter i_mem_arbiter (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .m0_req_i    ( m0_req    ),
    .m0_bus_i    ( m0_bus    ),
    .m0_ack_o    ( m0_ack    ),
    .m0_rdata_o  ( m0_rdata  ),
    .m1_req_i    ( m1_req    ),
    .m1_bus_i    ( m1_bus    ),
    .m1_ack_o    ( m1_ack    ),
    .m1_rdata_o  ( m1_rdata  ),
    .mem_en_o    ( mem_en    ),
    .mem_bus_o   ( mem_bus   ),
    .mem_rdata_i ( mem_rdata )
  );

  sram_bank #(
    .NumWords ( NumWords )
  ) i_sram_bank (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .mem_en_i    ( mem_en    ),
    .mem_bus_i   ( mem_bus   ),
    .mem_rdata_o ( mem_rdata )
  );

endmodule

// File: test/fixture_mini_soc.sv
`timescale 1ns/1ps

module fixture_mini_soc #(
  parameter int unsigned NumWords  = 256,
  parameter int unsigned MaxCycles = 100000
);

  import soc_pkg::*;

  logic      clk;
  logic      rst_n;
  logic      host_req;
  host_cmd_t host_cmd;
  logic      host_ack;
  host_rsp_t host_rsp;
  logic      copy_busy;

  // Status seen by the test module
  logic        mismatch_seen;
  logic        timed_out;
  logic        ack_in_reset;
  int unsigned busy_falls;
  int unsigned cycles;
  logic        busy_last;

  mini_soc #(
    .NumWords ( NumWords )
  ) mini_soc_i (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .host_req_i  ( host_req  ),
    .host_cmd_i  ( host_cmd  ),
    .host_ack_o  ( host_ack  ),
    .host_rsp_o  ( host_rsp  ),
    .copy_busy_o ( copy_busy )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock, reset and monitors
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst_n         = 1'b0;
    host_req      = 1'b0;
    host_cmd      = '0;
    mismatch_seen = 1'b0;
    timed_out     = 1'b0;
    ack_in_reset  = 1'b0;
    busy_falls    = 0;
    busy_last     = 1'b0;
    cycles        = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  // Sampled mid-cycle, away from the active edge
  always @(negedge clk) begin
    if (!rst_n && host_ack !== 1'b0) begin
      ack_in_reset = 1'b1;
    end
    if (busy_last && !copy_busy) begin
      busy_falls = busy_falls + 1;
    end
    busy_last = copy_busy;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == MaxCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
      timed_out = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host driver
  ////////////////////////////////////////////////////////////////////////////

  // Full four-phase cycle, response taken while ack is high
  task automatic run_handshake(input host_cmd_t cmd, output host_rsp_t rsp);
    @(negedge clk);
    host_cmd = cmd;
    host_req = 1'b1;
    do @(negedge clk); while (host_ack !== 1'b1);
    rsp      = host_rsp;
    host_req = 1'b0;
    do @(negedge clk); while (host_ack !== 1'b0);
  endtask

  task automatic host_write(input addr_t addr, input data_t data);
    host_cmd_t cmd;
    host_rsp_t rsp;
    cmd       = '0;
    cmd.op    = OP_WRITE;
    cmd.addr  = addr;
    cmd.wdata = data;
    run_handshake(cmd, rsp);
  endtask

  task automatic host_read(input addr_t addr, output data_t data);
    host_cmd_t cmd;
    host_rsp_t rsp;
    cmd      = '0;
    cmd.op   = OP_READ;
    cmd.addr = addr;
    run_handshake(cmd, rsp);
    data = rsp.rdata;
  endtask

  task automatic host_status(output logic busy);
    host_cmd_t cmd;
    host_rsp_t rsp;
    cmd    = '0;
    cmd.op = OP_STATUS;
    run_handshake(cmd, rsp);
    busy = rsp.busy;
  endtask

  // Returns once the job is accepted, the copy itself runs on
  task automatic host_copy(input addr_t src, input addr_t dst, input len_t len);
    host_cmd_t cmd;
    host_rsp_t rsp;
    cmd      = '0;
    cmd.op   = OP_COPY;
    cmd.addr = dst;
    cmd.src  = src;
    cmd.len  = len;
    run_handshake(cmd, rsp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      mismatch_seen = 1'b1;
      @(posedge clk);
    end
  endtask

  task automatic check_busy(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      mismatch_seen = 1'b1;
      @(posedge clk);
    end
  endtask

endmodule

// File: test/tb_mini_soc.sv
`timescale 1ns/1ps

module tb_mini_soc #(
  parameter int unsigned NumWords = 256
);

  import soc_pkg::*;

  // Test sizes
  localparam int unsigned RandOps    = 32;
  localparam int unsigned TrafficOps = 16;
  localparam int unsigned WrapLen    = 24;
  localparam int unsigned LongLen    = NumWords / 4;
  localparam int unsigned FirstLen   = 32;
  localparam int unsigned SecondLen  = 8;

  // Worst case per host command and per copied word under contention
  localparam int unsigned HostOpCycles   = 16;
  localparam int unsigned CopyWordCycles = 24;
  // Preload plus four full scans, random pairs, traffic triples, statuses
  localparam int unsigned HostOps   = 5 * NumWords + 2 * RandOps + 3 * TrafficOps + 16;
  localparam int unsigned CopyWords = WrapLen + LongLen + FirstLen + SecondLen;
  localparam int unsigned MaxCycles =
    2 * (16 + HostOps * HostOpCycles + CopyWords * CopyWordCycles);

  data_t       model [NumWords];
  logic [31:0] lcg_state = 32'h024d_5d10;

  fixture_mini_soc #(
    .NumWords  ( NumWords  ),
    .MaxCycles ( MaxCycles )
  ) fix ();

  ////////////////////////////////////////////////////////////////////////////
  // Reference model helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic addr_t wrap_index(input int a);
    return addr_t'(a % int'(NumWords));
  endfunction

  // Every byte depends on the full address
  function automatic data_t fill_word(input int a);
    logic [7:0] b;
    b = 8'(a);
    return {b, ~b, b ^ 8'h5a, b + 8'h3c};
  endfunction

  // Ascending, one word at a time, so overlaps behave like the engine
  task automatic apply_copy(input addr_t src, input addr_t dst, input len_t len);
    for (int i = 0; i < int'(len); i++) begin
      model[wrap_index(int'(dst) + i)] = model[wrap_index(int'(src) + i)];
    end
  endtask

  task automatic scan_memory();
    data_t got;
    for (int a = 0; a < int'(NumWords); a++) begin
      fix.host_read(addr_t'(a), got);
      fix.check_data($sformatf("host_rsp_o.rdata[0x%02h]", a), got, model[addr_t'(a)]);
    end
  endtask

  task automatic wait_copy_idle();
    logic busy;
    do begin
      fix.host_status(busy);
    end while (busy);
  endtask

  task automatic stop_failed();
    $display("Checks failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset_status();
    logic busy;
    fix.check_busy("host_ack_o during reset", fix.ack_in_reset, 1'b0);
    fix.host_status(busy);
    fix.check_busy("host_rsp_o.busy after reset", busy, 1'b0);
  endtask

  task automatic preload_memory();
    for (int a = 0; a < int'(NumWords); a++) begin
      fix.host_write(addr_t'(a), fill_word(a));
      model[addr_t'(a)] = fill_word(a);
    end
  endtask

  task automatic write_read_random();
    addr_t addrs [RandOps];
    data_t val;
    data_t got;
    for (int i = 0; i < int'(RandOps); i++) begin
      addrs[i] = addr_t'(next_rand() >> 16);
      val      = next_rand();
      fix.host_write(addrs[i], val);
      model[wrap_index(int'(addrs[i]))] = val;
    end
    for (int i = 0; i < int'(RandOps); i++) begin
      fix.host_read(addrs[i], got);
      fix.check_data($sformatf("host_rsp_o.rdata[0x%02h]", addrs[i]), got,
                     model[wrap_index(int'(addrs[i]))]);
    end
  endtask

  // Source runs past the top of the address space
  task automatic copy_with_wrap();
    fix.host_copy(addr_t'(240), addr_t'(40), len_t'(WrapLen));
    apply_copy(addr_t'(240), addr_t'(40), len_t'(WrapLen));
    wait_copy_idle();
    scan_memory();
  endtask

  // Host traffic stays in the lower half, the copy in the upper half
  task automatic copy_under_traffic();
    addr_t src;
    addr_t dst;
    addr_t a;
    data_t val;
    data_t got;
    logic  busy;
    logic  busy_seen;
    src       = addr_t'(NumWords / 2);
    dst       = addr_t'(NumWords / 2 + NumWords / 4);
    busy_seen = 1'b0;
    fix.host_copy(src, dst, len_t'(LongLen));
    apply_copy(src, dst, len_t'(LongLen));
    for (int i = 0; i < int'(TrafficOps); i++) begin
      a   = addr_t'(next_rand() % (NumWords / 2));
      val = next_rand();
      fix.host_write(a, val);
      model[wrap_index(int'(a))] = val;
      fix.host_status(busy);
      busy_seen = busy_seen | busy;
      fix.host_read(a, got);
      fix.check_data($sformatf("host_rsp_o.rdata[0x%02h]", a), got, model[wrap_index(int'(a))]);
    end
    fix.check_busy("host_rsp_o.busy during copy", busy_seen, 1'b1);
    wait_copy_idle();
    scan_memory();
  endtask

  task automatic copy_back_pressure();
    int unsigned falls;
    falls = fix.busy_falls;
    fix.host_copy(addr_t'(16), addr_t'(100), len_t'(FirstLen));
    apply_copy(addr_t'(16), addr_t'(100), len_t'(FirstLen));
    fix.host_copy(addr_t'(60), addr_t'(140), len_t'(SecondLen));
    apply_copy(addr_t'(60), addr_t'(140), len_t'(SecondLen));
    // Exactly the first job ended before the second was acknowledged
    fix.check_data("copy_busy_o falls before second ack", data_t'(fix.busy_falls - falls),
                   data_t'(1));
    wait_copy_idle();
    scan_memory();
  endtask

  task automatic copy_zero_length();
    logic busy;
    fix.host_copy(addr_t'(200), addr_t'(10), len_t'(0));
    fix.host_status(busy);
    fix.check_busy("host_rsp_o.busy after zero-length copy", busy, 1'b0);
    scan_memory();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    wait (fix.rst_n === 1'b1);
    check_reset_status();
    preload_memory();
    write_read_random();
    copy_with_wrap();
    copy_under_traffic();
    copy_back_pressure();
    copy_zero_length();
    if (fix.mismatch_seen || fix.timed_out) begin
      stop_failed();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

  // First error or timeout ends the run
  initial begin
    wait (fix.mismatch_seen || fix.timed_out);
    stop_failed();
  end

endmodule

// File: build.f
rtl/soc_pkg.sv
rtl/sram_bank.sv
rtl/mem_arbiter.sv
rtl/host_port.sv
rtl/copy_engine.sv
rtl/mini_soc.sv
test/fixture_mini_soc.sv
test/tb_mini_soc.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 -f build.f --top-module tb_mini_soc \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_mini_soc > sim.log 2>&1
cat sim.log

[ -s sim.log ] || { echo "Simulation produced no output"; exit 1; }
grep -q "Checks failed" sim.log && { echo "Result: FAIL"; exit 1; }
echo "Result: PASS"
exit 0
